// ==== Bender.yml ====
package:
  name: frontend

sources:
  - design/frontend_pkg.sv
  - design/bp_update_if.sv
  - design/btb.sv
  - design/pht.sv
  - design/branch_predictor.sv
  - design/fetch_queue.sv
  - design/fetch_unit.sv
  - design/frontend_top.sv
  - target: test
    files:
      - verif/frontend_chk.sv
      - verif/frontend_tb.sv

// ==== design/bp_update_if.sv ====
`timescale 1ns/100ps

// training update sent by the core at retirement
interface bp_update_if;

    logic                          valid;  // one-cycle strobe
    logic [frontend_pkg::xlen-1:0] pc;     // pc of the resolved branch
    logic                          taken;  // actual direction
    logic [frontend_pkg::xlen-1:0] target; // actual target

    modport predictor (
        input valid,
        input pc,
        input taken,
        input target
    );

endinterface : bp_update_if

// ==== design/branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor #(
    parameter int unsigned BTB_IDX_BITS = frontend_pkg::btb_idx_bits,
    parameter int unsigned PHT_IDX_BITS = frontend_pkg::pht_idx_bits
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [frontend_pkg::xlen-1:0] lookup_pc_i,
    output logic                          pred_taken_o,
    output logic [frontend_pkg::xlen-1:0] pred_target_o,

    bp_update_if.predictor                upd
);

    logic [frontend_pkg::ghr_bits-1:0] ghr_q; // retired history only
    logic [PHT_IDX_BITS-1:0]           hist_idx;

    logic [PHT_IDX_BITS-1:0] lookup_idx;
    logic [PHT_IDX_BITS-1:0] upd_idx;

    logic       btb_hit;
    logic [1:0] ctr;

    // gshare hash, lookup and update share one history
    assign hist_idx = PHT_IDX_BITS'(ghr_q);
    assign lookup_idx = lookup_pc_i[PHT_IDX_BITS+1:2] ^ hist_idx;
    assign upd_idx = upd.pc[PHT_IDX_BITS+1:2] ^ hist_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr_q <= '0;
        end else if (upd.valid) begin
            ghr_q <= {ghr_q[frontend_pkg::ghr_bits-2:0], upd.taken}; // newest in bit 0
        end
    end

    btb #(
        .BTB_IDX_BITS (BTB_IDX_BITS)
    ) btb_i (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (lookup_pc_i),
        .hit_o       (btb_hit),
        .target_o    (pred_target_o),
        .wr_en_i     (upd.valid & upd.taken), // only taken branches own a target
        .wr_pc_i     (upd.pc),
        .wr_target_i (upd.target)
    );

    pht #(
        .PHT_IDX_BITS (PHT_IDX_BITS)
    ) pht_i (
        .clk         (clk),
        .rst         (rst),
        .rd_idx_i    (lookup_idx),
        .ctr_o       (ctr),
        .upd_en_i    (upd.valid),
        .upd_idx_i   (upd_idx),
        .upd_taken_i (upd.taken)
    );

    assign pred_taken_o = btb_hit & ctr[1]; // counter 2 or 3

endmodule : branch_predictor

// ==== design/btb.sv ====
`timescale 1ns/100ps

module btb #(
    parameter int unsigned BTB_IDX_BITS = frontend_pkg::btb_idx_bits
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [frontend_pkg::xlen-1:0] rd_pc_i,
    output logic                          hit_o,
    output logic [frontend_pkg::xlen-1:0] target_o,

    input  logic                          wr_en_i,
    input  logic [frontend_pkg::xlen-1:0] wr_pc_i,
    input  logic [frontend_pkg::xlen-1:0] wr_target_i
);

    localparam int unsigned ENTRIES = 2 ** BTB_IDX_BITS;

    logic [frontend_pkg::xlen-1:0] target_q [ENTRIES]; // target storage
    logic [ENTRIES-1:0]            valid_q;

    logic [BTB_IDX_BITS-1:0] rd_idx;
    logic [BTB_IDX_BITS-1:0] wr_idx;

    // untagged, word index above the byte offset
    assign rd_idx = rd_pc_i[BTB_IDX_BITS+1:2];
    assign wr_idx = wr_pc_i[BTB_IDX_BITS+1:2];

    assign hit_o = valid_q[rd_idx];
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule : btb

// ==== design/fetch_queue.sv ====
`timescale 1ns/100ps

module fetch_queue #(
    parameter int unsigned FQ_DEPTH = frontend_pkg::fq_depth
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush_i,

    input  logic                       push_i,
    input  frontend_pkg::fetch_entry_t push_entry_i,

    input  logic                       pop_i,
    output frontend_pkg::fetch_entry_t head_o,

    output logic                       empty_o,
    output logic                       full_o
);

    localparam int unsigned PTR_W = (FQ_DEPTH > 1) ? $clog2(FQ_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FQ_DEPTH + 1);

    frontend_pkg::fetch_entry_t mem [FQ_DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] free_slots;

    logic do_push;
    logic do_pop;

    assign free_slots = CNT_W'(FQ_DEPTH) - count_q;
    assign full_o = (free_slots == '0);
    assign empty_o = (count_q == '0);

    assign do_push = push_i & ~full_o;
    assign do_pop = pop_i & ~empty_o; // pop on empty is ignored

    assign head_o = mem[rd_ptr_q]; // zero-latency head

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_entry_i;
        end
    end

endmodule : fetch_queue

// ==== design/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          redirect_i,
    input  logic [frontend_pkg::xlen-1:0] redirect_pc_i,

    output logic                          imem_req_o,
    output logic [frontend_pkg::xlen-1:0] imem_addr_o,
    input  logic                          imem_resp_i,
    input  logic [frontend_pkg::xlen-1:0] imem_rdata_i,

    input  logic                          q_full_i,
    output logic                          q_push_o,
    output frontend_pkg::fetch_entry_t    q_entry_o,

    output logic [frontend_pkg::xlen-1:0] lookup_pc_o,
    input  logic                          pred_taken_i,
    input  logic [frontend_pkg::xlen-1:0] pred_target_i
);

    logic [frontend_pkg::xlen-1:0] pc_q; // address of the pending or next request
    logic [frontend_pkg::xlen-1:0] pc_d;

    logic outstanding_q; // request in flight
    logic dropped_q;     // in-flight response belongs to the old path
    logic keep_resp;

    // one request in flight at a time, never on a redirect
    assign imem_req_o = ~outstanding_q & ~q_full_i & ~rst & ~redirect_i;
    assign imem_addr_o = pc_q;

    assign keep_resp = imem_resp_i & ~dropped_q;

    // predict on the pc whose word is returning
    assign lookup_pc_o = pc_q;

    assign q_push_o = keep_resp;
    assign q_entry_o.pc = pc_q;
    assign q_entry_o.inst = imem_rdata_i;
    assign q_entry_o.pred_taken = pred_taken_i;
    assign q_entry_o.pred_target = pred_target_i;

    always_comb begin
        pc_d = pc_q;
        if (redirect_i) begin
            pc_d = redirect_pc_i; // redirect wins over a response
        end else if (keep_resp) begin
            pc_d = pred_taken_i ? pred_target_i : pc_q + frontend_pkg::pc_step;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= frontend_pkg::reset_pc;
            outstanding_q <= 1'b0;
            dropped_q <= 1'b0;
        end else begin
            pc_q <= pc_d;

            if (imem_resp_i) begin
                outstanding_q <= 1'b0;
            end else if (imem_req_o) begin
                outstanding_q <= 1'b1;
            end

            // the stale word is discarded when it finally shows up
            if (imem_resp_i) begin
                dropped_q <= 1'b0;
            end else if (redirect_i && outstanding_q) begin
                dropped_q <= 1'b1;
            end
        end
    end

endmodule : fetch_unit

// ==== design/frontend_pkg.sv ====
package frontend_pkg;

    // datapath and address width
    localparam int unsigned xlen = 32;

    localparam logic [xlen-1:0] reset_pc = 32'h1eceb000; // first fetch address
    localparam logic [xlen-1:0] pc_step = 32'd4;         // one word per fetch

    // predictor geometry
    localparam int unsigned btb_idx_bits = 8; // pc[9:2]
    localparam int unsigned pht_idx_bits = 8;
    localparam int unsigned ghr_bits = 8;     // retired history length

    // fetch queue
    localparam int unsigned fq_depth = 8;

    // 2-bit counter encodings
    localparam logic [1:0] ctr_strong_nt = 2'b00;
    localparam logic [1:0] ctr_weak_nt = 2'b01; // value of an invalid entry
    localparam logic [1:0] ctr_strong_t = 2'b11;

    // one fetch queue slot, 97 bits
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic            pred_taken;
        logic [xlen-1:0] pred_target;
    } fetch_entry_t;

endpackage : frontend_pkg

// ==== design/frontend_top.sv ====
`timescale 1ns/100ps

module frontend_top #(
    parameter int unsigned FQ_DEPTH = frontend_pkg::fq_depth,
    parameter int unsigned BTB_IDX_BITS = frontend_pkg::btb_idx_bits,
    parameter int unsigned PHT_IDX_BITS = frontend_pkg::pht_idx_bits
) (
    input  logic                          clk,
    input  logic                          rst,

    // instruction memory
    output logic                          imem_req_o,
    output logic [frontend_pkg::xlen-1:0] imem_addr_o,
    input  logic                          imem_resp_i,
    input  logic [frontend_pkg::xlen-1:0] imem_rdata_i,

    // redirect from the back end
    input  logic                          redirect_i,
    input  logic [frontend_pkg::xlen-1:0] redirect_pc_i,

    // retirement training
    input  logic                          resolve_valid_i,
    input  logic [frontend_pkg::xlen-1:0] resolve_pc_i,
    input  logic                          resolve_taken_i,
    input  logic [frontend_pkg::xlen-1:0] resolve_target_i,

    // consumer side
    input  logic                          fetch_pop_i,
    output logic                          fetch_valid_o,
    output logic [frontend_pkg::xlen-1:0] fetch_pc_o,
    output logic [frontend_pkg::xlen-1:0] fetch_inst_o,
    output logic                          fetch_pred_taken_o,
    output logic [frontend_pkg::xlen-1:0] fetch_pred_target_o
);

    logic                          q_full;
    logic                          q_empty;
    logic                          q_push;
    frontend_pkg::fetch_entry_t    q_entry;
    frontend_pkg::fetch_entry_t    q_head;

    logic [frontend_pkg::xlen-1:0] lookup_pc;
    logic                          pred_taken;
    logic [frontend_pkg::xlen-1:0] pred_target;

    bp_update_if upd_if ();

    assign upd_if.valid = resolve_valid_i;
    assign upd_if.pc = resolve_pc_i;
    assign upd_if.taken = resolve_taken_i;
    assign upd_if.target = resolve_target_i;

    fetch_unit fetch_unit_i (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .imem_resp_i   (imem_resp_i),
        .imem_rdata_i  (imem_rdata_i),
        .q_full_i      (q_full),
        .q_push_o      (q_push),
        .q_entry_o     (q_entry),
        .lookup_pc_o   (lookup_pc),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target)
    );

    branch_predictor #(
        .BTB_IDX_BITS (BTB_IDX_BITS),
        .PHT_IDX_BITS (PHT_IDX_BITS)
    ) branch_predictor_i (
        .clk           (clk),
        .rst           (rst),
        .lookup_pc_i   (lookup_pc),
        .pred_taken_o  (pred_taken),
        .pred_target_o (pred_target),
        .upd           (upd_if.predictor)
    );

    fetch_queue #(
        .FQ_DEPTH (FQ_DEPTH)
    ) fetch_queue_i (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (redirect_i), // redirect empties the queue
        .push_i       (q_push),
        .push_entry_i (q_entry),
        .pop_i        (fetch_pop_i),
        .head_o       (q_head),
        .empty_o      (q_empty),
        .full_o       (q_full)
    );

    assign fetch_valid_o = ~q_empty;
    assign fetch_pc_o = q_head.pc;
    assign fetch_inst_o = q_head.inst;
    assign fetch_pred_taken_o = q_head.pred_taken;
    assign fetch_pred_target_o = q_head.pred_target;

endmodule : frontend_top

// ==== design/pht.sv ====
`timescale 1ns/100ps

module pht #(
    parameter int unsigned PHT_IDX_BITS = frontend_pkg::pht_idx_bits
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic [PHT_IDX_BITS-1:0] rd_idx_i,
    output logic [1:0]              ctr_o,

    input  logic                    upd_en_i,
    input  logic [PHT_IDX_BITS-1:0] upd_idx_i,
    input  logic                    upd_taken_i
);

    localparam int unsigned ENTRIES = 2 ** PHT_IDX_BITS;

    logic [1:0]         ctr_q [ENTRIES];
    logic [ENTRIES-1:0] valid_q;

    logic [1:0] upd_cur;  // counter before the update
    logic [1:0] upd_next; // counter after saturation

    // untouched entries start weakly not taken
    assign ctr_o = valid_q[rd_idx_i] ? ctr_q[rd_idx_i] : frontend_pkg::ctr_weak_nt;
    assign upd_cur = valid_q[upd_idx_i] ? ctr_q[upd_idx_i] : frontend_pkg::ctr_weak_nt;

    always_comb begin
        upd_next = upd_cur;
        if (upd_taken_i) begin
            if (upd_cur != frontend_pkg::ctr_strong_t) begin
                upd_next = upd_cur + 2'd1;
            end
        end else begin
            if (upd_cur != frontend_pkg::ctr_strong_nt) begin
                upd_next = upd_cur - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (upd_en_i) begin
            valid_q[upd_idx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_en_i) begin
            ctr_q[upd_idx_i] <= upd_next;
        end
    end

endmodule : pht

// ==== src.f ====
design/frontend_pkg.sv
design/bp_update_if.sv
design/btb.sv
design/pht.sv
design/branch_predictor.sv
design/fetch_queue.sv
design/fetch_unit.sv
design/frontend_top.sv
verif/frontend_chk.sv
verif/frontend_tb.sv

// ==== verif/frontend_chk.sv ====
`timescale 1ns/100ps

module frontend_chk (
    input logic        clk,
    input logic        rst,
    input logic        imem_req_o,
    input logic [31:0] imem_addr_o,
    input logic        imem_resp_i,
    input logic        fetch_valid_o,
    input logic        redirect_i
);

    logic outstanding_q; // request seen, answer not yet

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding_q <= 1'b0;
        end else if (imem_resp_i) begin
            outstanding_q <= 1'b0;
        end else if (imem_req_o) begin
            outstanding_q <= 1'b1;
        end
    end

    a_one_outstanding : assert property (@(posedge clk) disable iff (rst)
        imem_req_o |-> !outstanding_q)
        else $error("second request while one is outstanding");

    a_word_aligned : assert property (@(posedge clk) disable iff (rst)
        imem_req_o |-> (imem_addr_o[1:0] == 2'b00))
        else $error("request address not word aligned");

    a_reset_quiet : assert property (@(posedge clk)
        rst |-> !imem_req_o ##1 !fetch_valid_o)
        else $error("request or valid fetch right after reset");

    a_no_req_on_redirect : assert property (@(posedge clk) disable iff (rst)
        redirect_i |-> !imem_req_o)
        else $error("request issued during a redirect");

endmodule : frontend_chk

bind frontend_top frontend_chk chk_i (
    .clk           (clk),
    .rst           (rst),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_resp_i   (imem_resp_i),
    .fetch_valid_o (fetch_valid_o),
    .redirect_i    (redirect_i)
);

// ==== verif/frontend_tb.sv ====
`timescale 1ns/100ps

module frontend_tb;

    localparam int unsigned period = 4;

    logic        clk = 1'b0;
    logic        rst;
    logic        imem_req_o;
    logic [31:0] imem_addr_o;
    logic        imem_resp_i;
    logic [31:0] imem_rdata_i;
    logic        redirect_i;
    logic [31:0] redirect_pc_i;
    logic        resolve_valid_i;
    logic [31:0] resolve_pc_i;
    logic        resolve_taken_i;
    logic [31:0] resolve_target_i;
    logic        fetch_pop_i;
    logic        fetch_valid_o;
    logic [31:0] fetch_pc_o;
    logic [31:0] fetch_inst_o;
    logic        fetch_pred_taken_o;
    logic [31:0] fetch_pred_target_o;

    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned lcg_state = 14;
    bit          loaded = 1'b0;

    string       op_name [$];
    logic [31:0] op_a [$];
    logic [31:0] op_b [$];
    logic [31:0] op_c [$];
    logic [31:0] exp_pc [$];  // pcs named by the trace

    // reference predictor and expected queue contents
    frontend_pkg::fetch_entry_t model_q [$];
    logic [31:0] m_pc;
    logic [7:0]  m_ghr = '0;
    logic [31:0] m_btb_tgt [256];
    bit          m_btb_valid [256];
    logic [1:0]  m_pht_ctr [256];
    bit          m_pht_valid [256];

    // memory model state
    bit          pending = 1'b0;
    int unsigned lat_cnt;
    logic [31:0] pend_addr;

    always #2 clk = ~clk;

    frontend_top dut_i (.*);

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a5ac3c3; // every address bit matters
    endfunction

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [1:0] ctr_at(input logic [31:0] pc);
        logic [7:0] idx;
        idx = pc[9:2] ^ m_ghr;
        return m_pht_valid[idx] ? m_pht_ctr[idx] : 2'b01;
    endfunction

    task automatic model_fetch();
        frontend_pkg::fetch_entry_t e;
        e.pc = m_pc;
        e.inst = mem_word(m_pc);
        e.pred_taken = m_btb_valid[m_pc[9:2]] && (ctr_at(m_pc) >= 2'd2);
        e.pred_target = m_btb_tgt[m_pc[9:2]];
        model_q.push_back(e);
        m_pc = e.pred_taken ? e.pred_target : m_pc + 32'd4;
    endtask

    task automatic model_train(input logic [31:0] pc, input logic taken,
                               input logic [31:0] tgt);
        logic [7:0] idx;
        logic [1:0] c;
        idx = pc[9:2] ^ m_ghr;
        c = ctr_at(pc);
        if (taken) begin
            c = (c == 2'd3) ? c : c + 2'd1;
            m_btb_tgt[pc[9:2]] = tgt;
            m_btb_valid[pc[9:2]] = 1'b1;
        end else begin
            c = (c == 2'd0) ? c : c - 2'd1;
        end
        m_pht_ctr[idx] = c;
        m_pht_valid[idx] = 1'b1;
        m_ghr = {m_ghr[6:0], taken};
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_head();
        frontend_pkg::fetch_entry_t e;
        if (model_q.size() == 0) begin
            model_fetch();
        end
        e = model_q.pop_front();
        compare_field("fetch_pc_o", fetch_pc_o, e.pc);
        compare_field("fetch_inst_o", fetch_inst_o, e.inst);
        compare_field("fetch_pred_taken_o", 32'(fetch_pred_taken_o), 32'(e.pred_taken));
        if (e.pred_taken) begin
            compare_field("fetch_pred_target_o", fetch_pred_target_o, e.pred_target);
        end
        if (exp_pc.size() > 0) begin
            compare_field("fetch_pc_o vs trace", fetch_pc_o, exp_pc.pop_front());
        end
    endtask

    // a request seen in this cycle starts a new memory access
    task automatic capture_request();
        #1;
        if (imem_req_o) begin
            pending = 1'b1;
            pend_addr = imem_addr_o;
            lat_cnt = (lcg_next() >> 16) % 4 + 1; // 1 to 4 cycles
        end
    endtask

    // one cycle of memory answer, pop check, inputs and request capture
    task automatic step(input logic pop_en, input logic redir, input logic [31:0] rpc,
                        input logic res_v, input logic [31:0] res_pc,
                        input logic res_t, input logic [31:0] res_tgt);
        @(negedge clk);
        imem_resp_i = 1'b0;
        if (pending) begin
            if (lat_cnt == 1) begin
                imem_resp_i = 1'b1;
                imem_rdata_i = mem_word(pend_addr);
                pending = 1'b0;
            end else begin
                lat_cnt--;
            end
        end
        fetch_pop_i = 1'b0;
        if (pop_en && fetch_valid_o) begin
            check_head();
            fetch_pop_i = 1'b1;
        end
        redirect_i = redir;
        redirect_pc_i = rpc;
        resolve_valid_i = res_v;
        resolve_pc_i = res_pc;
        resolve_taken_i = res_t;
        resolve_target_i = res_tgt;
        capture_request();
    endtask

    task automatic read_trace();
        int    fd;
        string line;
        string name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("verif/frontend_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the trace file");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            a = '0;
            b = '0;
            c = '0;
            void'($sscanf(line, "%s %h %h %h", name, a, b, c));
            op_name.push_back(name);
            op_a.push_back(a);
            op_b.push_back(b);
            op_c.push_back(c);
        end
        $fclose(fd);
    endtask

    initial begin
        wait (loaded);
        #(200 * op_name.size() * period);
        errors++;
        $display("watchdog expired before the trace finished");
        $display("errors: %0d  checks: %0d", errors, checks);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst = 1'b1;
        imem_resp_i = 1'b0;
        imem_rdata_i = '0;
        redirect_i = 1'b0;
        redirect_pc_i = '0;
        resolve_valid_i = 1'b0;
        resolve_pc_i = '0;
        resolve_taken_i = 1'b0;
        resolve_target_i = '0;
        fetch_pop_i = 1'b0;
        m_pc = frontend_pkg::reset_pc;
        read_trace();
        loaded = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        capture_request(); // first request leaves in the cycle reset drops
        foreach (op_name[i]) begin
            case (op_name[i])
                "run":   repeat (op_a[i]) step(1'b1, 1'b0, '0, 1'b0, '0, 1'b0, '0);
                "stall": repeat (op_a[i]) step(1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
                "resolve": begin
                    // the full queue was predicted with the old tables
                    while (model_q.size() < frontend_pkg::fq_depth) model_fetch();
                    step(1'b0, 1'b0, '0, 1'b1, op_a[i], op_b[i][0], op_c[i]);
                    model_train(op_a[i], op_b[i][0], op_c[i]);
                end
                "redirect": begin
                    step(1'b0, 1'b1, op_a[i], 1'b0, '0, 1'b0, '0);
                    model_q.delete();
                    m_pc = op_a[i];
                end
                "expect": exp_pc.push_back(op_a[i]);
                default: begin
                    errors++;
                    $display("unknown trace operation %s", op_name[i]);
                end
            endcase
        end
        step(1'b0, 1'b0, '0, 1'b0, '0, 1'b0, '0);
        if (exp_pc.size() != 0) begin
            errors++;
            $display("%0d expected pcs from the trace were never popped", exp_pc.size());
        end
        $display("errors: %0d  checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : frontend_tb

// ==== verif/frontend_trace.txt ====
# columns: op a b c, all numbers hex
# run/stall n cycles, resolve pc taken target, redirect pc, expect pc of a coming pop
expect 1eceb000
expect 1eceb004
expect 1eceb008
run 1e
stall 3c
run 28
redirect 1ecec100
expect 1ecec100
expect 1ecec104
run 14
stall 3c
resolve 1eced040 1 1eced400
resolve 1eced040 1 1eced400
resolve 1eced040 1 1eced400
resolve 1eced040 1 1eced400
resolve 1eced040 1 1eced400
resolve 1eced040 1 1eced400
resolve 1eced040 1 1eced400
resolve 1eced040 1 1eced400
resolve 1eced040 1 1eced400
resolve 1eced040 1 1eced400
redirect 1eced040
expect 1eced040
expect 1eced400
run 14
stall 3c
resolve 1eced040 0 0
resolve 1eced040 0 0
resolve 1eced040 0 0
redirect 1eced040
expect 1eced040
expect 1eced044
run 14
